// File: tb.f
hw/core_pkg.sv
hw/exec_if.sv
hw/gpr_if.sv
hw/alu.sv
hw/decoder.sv
hw/execute_unit.sv
hw/reg_file.sv
hw/instr_sequencer.sv
hw/rv_core.sv
dv/core_assert.sv
dv/tb_top.sv

// File: run.sh
#!/bin/sh
# build and run the rv_core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module tb_top -o sim_tb > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    exit 1
fi
if grep -q "TEST FAILED" sim.log; then
    exit 1
fi
exit 0

// File: dv/tb_top.sv
//##########################################################################
// random instructions from a slow memory drive rv_core and each retire
// is checked against an instruction-set model
//##########################################################################
`timescale 1ns/10ps

module tb_top;

    localparam logic [31:0] reset_pc   = 32'h8000_0000;
    localparam int          n_instr    = 2000;
    localparam int          max_cycles = n_instr * 6 + 200;   // up to 5 cycles per instruction

    logic        clk = 1'b0;
    logic        reset, imem_req, imem_valid, retire_valid, retire_wen;
    logic [31:0] imem_addr, imem_data, retire_pc, retire_wdata;
    logic [4:0]  retire_rd;

    // model state
    logic [31:0] xreg [32];
    logic [31:0] m_pc, pend_inst;
    logic        busy;
    logic        resp_sent;   // response handed over at the last falling edge
    int          wait_cnt, retired, cycles;

    rv_core #(.reset_pc(reset_pc)) dut (.*);

    always #20 clk = ~clk;

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp)
            else fail_now($sformatf("mismatch %s: got %h expected %h", name, got, exp));
    endtask

    // RV32I arithmetic where alt selects sub or sra
    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return {31'b0, $signed(a) < $signed(b)};
            3'd3:    return {31'b0, a < b};
            3'd4:    return a ^ b;
            3'd5: begin
                if (alt)
                    return $signed(a) >>> b[4:0];
                else
                    return a >> b[4:0];
            end
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    // random instruction of a kept format or now and then an unknown opcode
    function automatic logic [31:0] gen_inst();
        logic [31:0] r;
        r = $urandom;
        case ($urandom % 8)
            0:       r[6:0] = 7'h33;
            1, 2:    r[6:0] = 7'h13;
            3:       r[6:0] = ($urandom % 2 == 1) ? 7'h37 : 7'h17;
            4, 5:    r[6:0] = 7'h63;
            6:       r[6:0] = 7'h6f;
            default: r[6:0] = ($urandom % 4 == 0) ? 7'h0b : 7'h67;
        endcase
        // only sub, sra and srai set funct7 bit 5
        if (r[6:0] == 7'h33 || (r[6:0] == 7'h13 && r[13:12] == 2'b01))
            r[31:25] = {1'b0, r[30] && (r[14:12] == 3'd0 || r[14:12] == 3'd5), 5'b0};
        if (r[6:0] == 7'h63 && r[14:13] == 2'b01) r[14] = 1'b1;   // no funct3 2 or 3
        if (r[6:0] == 7'h63 && $urandom % 4 == 0) r[24:20] = r[19:15];   // equal operands
        if (r[6:0] == 7'h67) r[14:12] = 3'd0;
        return r;
    endfunction

    task automatic retire_check(input logic [31:0] ins);
        logic [31:0] a, b, imm_i, wdata, next_pc;
        logic        wen, take;
        a       = xreg[ins[19:15]];
        b       = xreg[ins[24:20]];
        imm_i   = {{20{ins[31]}}, ins[31:20]};
        wen     = 1'b1;
        wdata   = m_pc + 4;    // link value for jumps
        next_pc = m_pc + 4;
        case (ins[6:0])
            7'h33: wdata = alu_ref(ins[14:12], ins[30], a, b);
            7'h13: wdata = alu_ref(ins[14:12], ins[30] && ins[14:12] == 3'd5, a, imm_i);
            7'h37: wdata = {ins[31:12], 12'h0};
            7'h17: wdata = m_pc + {ins[31:12], 12'h0};
            7'h6f: next_pc = m_pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            7'h67: next_pc = (a + imm_i) & ~32'h1;
            7'h63: begin
                wen = 1'b0;
                case (ins[14:12])
                    3'd0:    take = a == b;
                    3'd1:    take = a != b;
                    3'd4:    take = $signed(a) < $signed(b);
                    3'd5:    take = $signed(a) >= $signed(b);
                    3'd6:    take = a < b;
                    default: take = a >= b;
                endcase
                if (take)
                    next_pc = m_pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            end
            default: wen = 1'b0;   // unknown opcode retires as a no-op
        endcase
        check_word("retire_pc", retire_pc, m_pc);
        check_word("retire_rd", {27'b0, retire_rd}, {27'b0, ins[11:7]});
        assert (retire_wen === wen)
            else fail_now($sformatf("mismatch retire_wen: got %h expected %h", retire_wen, wen));
        if (wen) begin
            check_word("retire_wdata", retire_wdata, wdata);
            if (ins[11:7] != 5'd0) xreg[ins[11:7]] = wdata;   // x0 stays zero
        end
        m_pc = next_pc;
    endtask

    always @(posedge clk) begin
        cycles++;
        assert (cycles < max_cycles)
            else fail_now("timeout: the core stopped retiring instructions");
    end

    initial begin
        void'($urandom(4));
        reset      = 1'b1;
        imem_valid = 1'b0;
        imem_data  = '0;
        busy       = 1'b0;
        resp_sent  = 1'b0;
        wait_cnt   = 0;
        retired    = 0;
        m_pc       = reset_pc;   // first fetch address
        xreg       = '{default: '0};
        repeat (3) @(posedge clk);
        @(negedge clk);
        assert (!imem_req && !retire_valid)
            else fail_now("fetch or retire active while reset is held");
        reset = 1'b0;
        while (retired < n_instr) begin
            @(negedge clk);
            // retire exactly one cycle after the response, fetch in every other cycle
            check_word("retire_valid", {31'b0, retire_valid}, {31'b0, resp_sent});
            check_word("imem_req", {31'b0, imem_req}, {31'b0, !resp_sent});
            if (retire_valid) begin
                retire_check(pend_inst);
                retired++;
            end
            if (imem_req) begin
                if (!busy) begin
                    busy      = 1'b1;
                    wait_cnt  = $urandom % 4;   // 0 to 3 wait cycles
                    pend_inst = gen_inst();
                end
                check_word("imem_addr", imem_addr, m_pc);
                imem_valid = (wait_cnt == 0);
                imem_data  = imem_valid ? pend_inst : $urandom;
                busy       = !imem_valid;
                wait_cnt--;
            end else begin
                // noise on the response while no request is open
                imem_valid = ($urandom % 2) == 1;
                imem_data  = $urandom;
            end
            resp_sent = imem_req && imem_valid;
        end
        $display("TEST PASSED");
        $finish;
    end

endmodule

// File: dv/core_assert.sv
//##########################################################################
// fetch and retire protocol checks, bound into rv_core
//##########################################################################
`timescale 1ns/10ps

module core_assert (
    input logic        clk,
    input logic        reset,
    input logic        imem_req,
    input logic [31:0] imem_addr,
    input logic        imem_valid,
    input logic        retire_valid
);

    // fetch and retire never share a cycle
    no_overlap: assert property (@(posedge clk) disable iff (reset)
        !(imem_req && retire_valid))
        else $error("imem_req and retire_valid high in the same cycle");

    addr_held: assert property (@(posedge clk) disable iff (reset)
        imem_req && !imem_valid |=> imem_req && $stable(imem_addr))   // until the response
        else $error("fetch request dropped or address changed before the response");

    fetch_after_retire: assert property (@(posedge clk) disable iff (reset)
        retire_valid |=> imem_req)
        else $error("no fetch request in the cycle after a retire");

endmodule

bind rv_core core_assert u_assert (
    .clk          (clk),
    .reset        (reset),
    .imem_req     (imem_req),
    .imem_addr    (imem_addr),
    .imem_valid   (imem_valid),
    .retire_valid (retire_valid)
);

// File: hw/rv_core.sv
//##########################################################################
// multicycle RV32I core top: fetch port in, retire report out
//##########################################################################
`timescale 1ns/10ps

module rv_core import core_pkg::*; #(
    parameter word_t reset_pc = 32'h8000_0000
) (
    input  logic      clk,
    input  logic      reset,
    output logic      imem_req,
    output word_t     imem_addr,
    input  logic      imem_valid,
    input  word_t     imem_data,
    output logic      retire_valid,
    output word_t     retire_pc,
    output reg_addr_t retire_rd,
    output logic      retire_wen,
    output word_t     retire_wdata
);

    exec_if   ex_bus ();
    gpr_if    gpr_bus ();
    decoded_t dec;

    instr_sequencer #(
        .reset_pc (reset_pc)
    ) u_seq (
        .clk          (clk),
        .reset        (reset),
        .imem_req     (imem_req),
        .imem_addr    (imem_addr),
        .imem_valid   (imem_valid),
        .imem_data    (imem_data),
        .ex           (ex_bus.seq),
        .retire_valid (retire_valid)
    );

    decoder u_dec (
        .inst (ex_bus.inst),
        .dec  (dec)
    );

    execute_unit u_exu (
        .ex      (ex_bus.exu),
        .gpr     (gpr_bus.user),
        .dec     (dec),
        .wb_en   (retire_wen),
        .wb_data (retire_wdata)
    );

    reg_file u_gpr (
        .clk   (clk),
        .reset (reset),
        .gpr   (gpr_bus.regs)
    );

    assign retire_pc = ex_bus.pc;
    assign retire_rd = dec.rd;

endmodule

// File: hw/instr_sequencer.sv
//##########################################################################
// pc, FETCH/EXEC state machine and instruction register; drives the fetch
// request and flags the retire cycle
//##########################################################################
`timescale 1ns/10ps

module instr_sequencer import core_pkg::*; #(
    parameter word_t reset_pc = 32'h8000_0000
) (
    input  logic  clk,
    input  logic  reset,
    output logic  imem_req,
    output word_t imem_addr,
    input  logic  imem_valid,
    input  word_t imem_data,
    exec_if.seq   ex,
    output logic  retire_valid
);

    typedef enum logic {
        st_fetch,
        st_exec
    } state_t;

    state_t state;
    logic   req_q;       // low during reset and in EXEC
    word_t  pc;
    word_t  inst_q;
    logic   fetch_done;

    assign fetch_done = req_q && imem_valid;   // valid ignored without a request

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= st_fetch;
            req_q <= 1'b0;
            pc    <= reset_pc;
        end else begin
            case (state)
                st_fetch: begin
                    req_q <= !fetch_done;
                    if (fetch_done) state <= st_exec;
                end
                st_exec: begin
                    state <= st_fetch;
                    req_q <= 1'b1;
                    pc    <= ex.jump_en ? ex.jump_target : pc + word_t'(4);
                end
            endcase
        end
    end

    // instruction register loads on the response
    always_ff @(posedge clk) begin
        if (fetch_done) inst_q <= imem_data;
    end

    assign imem_req      = req_q;
    assign imem_addr     = pc;      // held until the response
    assign ex.inst       = inst_q;
    assign ex.pc         = pc;
    assign ex.exec_valid = (state == st_exec);
    assign retire_valid  = (state == st_exec);

endmodule

// File: hw/reg_file.sv
//##########################################################################
// 32 x 32 general purpose registers, x0 hardwired to zero
//##########################################################################
`timescale 1ns/10ps

module reg_file import core_pkg::*; (
    input  logic clk,
    input  logic reset,
    gpr_if.regs  gpr
);

    word_t regs [32];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (gpr.wen && gpr.waddr != '0) begin
            regs[gpr.waddr] <= gpr.wdata;
        end
    end

    // combinational reads
    assign gpr.rdata1 = (gpr.raddr1 == '0) ? '0 : regs[gpr.raddr1];
    assign gpr.rdata2 = (gpr.raddr2 == '0) ? '0 : regs[gpr.raddr2];

endmodule

// File: hw/execute_unit.sv
//##########################################################################
// operand select, branch/jump resolution and write-back select around
// the ALU; writes the register file during the EXEC cycle
//##########################################################################
`timescale 1ns/10ps

module execute_unit import core_pkg::*; (
    exec_if.exu      ex,
    gpr_if.user      gpr,
    input  decoded_t dec,
    output logic     wb_en,
    output word_t    wb_data
);

    word_t alu_a;
    word_t alu_b;
    word_t alu_result;
    logic  take_branch;

    alu u_alu (
        .a      (alu_a),
        .b      (alu_b),
        .op     (dec.alu_op),
        .result (alu_result)
    );

    always_comb begin
        case (dec.kind)
            kind_r:         begin alu_a = gpr.rdata1; alu_b = gpr.rdata2; end
            kind_i:         begin alu_a = gpr.rdata1; alu_b = dec.imm;    end
            kind_u:         begin alu_a = (dec.opcode == opc_lui) ? '0 : ex.pc; alu_b = dec.imm; end
            kind_b, kind_j: begin alu_a = ex.pc;      alu_b = dec.imm;    end
            default:        begin alu_a = '0;         alu_b = '0;         end
        endcase
    end

    always_comb begin
        case (dec.funct3)
            3'b000:  take_branch = (gpr.rdata1 == gpr.rdata2);
            3'b001:  take_branch = (gpr.rdata1 != gpr.rdata2);
            3'b100:  take_branch = ($signed(gpr.rdata1) < $signed(gpr.rdata2));
            3'b101:  take_branch = ($signed(gpr.rdata1) >= $signed(gpr.rdata2));
            3'b110:  take_branch = (gpr.rdata1 < gpr.rdata2);
            3'b111:  take_branch = (gpr.rdata1 >= gpr.rdata2);
            default: take_branch = 1'b0;
        endcase
    end

    assign ex.jump_en = (dec.kind == kind_b && take_branch) ||
                        dec.opcode == opc_jal || dec.opcode == opc_jalr;
    assign ex.jump_target = (dec.opcode == opc_jalr) ? {alu_result[31:1], 1'b0} : alu_result;

    always_comb begin
        case (dec.opcode)
            opc_jal, opc_jalr: begin wb_en = 1'b1; wb_data = ex.pc + word_t'(4); end  // link
            opc_op, opc_op_imm, opc_lui, opc_auipc: begin wb_en = 1'b1; wb_data = alu_result; end
            default:           begin wb_en = 1'b0; wb_data = '0; end
        endcase
    end

    assign gpr.raddr1 = dec.rs1;
    assign gpr.raddr2 = dec.rs2;
    assign gpr.waddr  = dec.rd;
    assign gpr.wdata  = wb_data;
    assign gpr.wen    = wb_en && ex.exec_valid;   // one write per instruction

endmodule

// File: hw/decoder.sv
//##########################################################################
// instruction decode: fields, format, sign-extended immediate, ALU op
//##########################################################################
`timescale 1ns/10ps

module decoder import core_pkg::*; (
    input  word_t    inst,
    output decoded_t dec
);

    logic [6:0] funct7;

    assign funct7 = inst[31:25];

    always_comb begin
        dec.opcode = inst[6:0];
        dec.funct3 = inst[14:12];
        dec.rd     = inst[11:7];
        dec.rs1    = inst[19:15];
        dec.rs2    = inst[24:20];

        case (inst[6:0])
            opc_op:               dec.kind = kind_r;
            opc_op_imm, opc_jalr: dec.kind = kind_i;
            opc_lui, opc_auipc:   dec.kind = kind_u;
            opc_branch:           dec.kind = kind_b;
            opc_jal:              dec.kind = kind_j;
            default:              dec.kind = kind_none;   // retires as a no-op
        endcase

        case (dec.kind)
            kind_i:  dec.imm = {{20{inst[31]}}, inst[31:20]};
            kind_u:  dec.imm = {inst[31:12], 12'b0};
            kind_b:  dec.imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            kind_j:  dec.imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            default: dec.imm = '0;
        endcase

        // arithmetic ops only, everything else adds
        dec.alu_op = alu_add;
        if (inst[6:0] == opc_op || inst[6:0] == opc_op_imm) begin
            case (inst[14:12])
                3'b000: begin
                    if (dec.kind == kind_r && funct7 == 7'b0100000) dec.alu_op = alu_sub;
                end
                3'b001:  dec.alu_op = alu_sll;
                3'b010:  dec.alu_op = alu_slt;
                3'b011:  dec.alu_op = alu_sltu;
                3'b100:  dec.alu_op = alu_xor;
                3'b101:  dec.alu_op = funct7[5] ? alu_sra : alu_srl;   // srai shares bit 30
                3'b110:  dec.alu_op = alu_or;
                default: dec.alu_op = alu_and;
            endcase
        end
    end

endmodule

// File: hw/alu.sv
//##########################################################################
// integer ALU with the ten RV32I operations
//##########################################################################
`timescale 1ns/10ps

module alu import core_pkg::*; (
    input  word_t   a,
    input  word_t   b,
    input  alu_op_t op,
    output word_t   result
);

    always_comb begin
        case (op)
            alu_add:  result = a + b;
            alu_sub:  result = a - b;
            alu_sll:  result = a << b[4:0];
            alu_slt:  result = word_t'($signed(a) < $signed(b));
            alu_sltu: result = word_t'(a < b);
            alu_xor:  result = a ^ b;
            alu_srl:  result = a >> b[4:0];
            alu_sra:  result = word_t'($signed(a) >>> b[4:0]);
            alu_or:   result = a | b;
            alu_and:  result = a & b;
            default:  result = a + b;
        endcase
    end

endmodule

// File: hw/gpr_if.sv
//##########################################################################
// register file access from the execute unit, two reads and one write
//##########################################################################
`timescale 1ns/10ps

interface gpr_if import core_pkg::*; ();

    reg_addr_t raddr1;
    reg_addr_t raddr2;
    logic      wen;
    reg_addr_t waddr;
    word_t     wdata;
    word_t     rdata1;   // combinational read data
    word_t     rdata2;

    modport user (output raddr1, raddr2, wen, waddr, wdata, input rdata1, rdata2);
    modport regs (input raddr1, raddr2, wen, waddr, wdata, output rdata1, rdata2);

endinterface

// File: hw/exec_if.sv
//##########################################################################
// sequencer to execute unit link: current instruction and jump result
//##########################################################################
`timescale 1ns/10ps

interface exec_if import core_pkg::*; ();

    word_t inst;
    word_t pc;
    logic  exec_valid;   // high for the single EXEC cycle
    logic  jump_en;
    word_t jump_target;

    modport seq (output inst, pc, exec_valid, input jump_en, jump_target);
    modport exu (input pc, exec_valid, output jump_en, jump_target);

endinterface

// File: hw/core_pkg.sv
//##########################################################################
// shared widths, opcodes, ALU operations and decoded-instruction struct
// for the multicycle RV32I core; imported by every RTL file
//##########################################################################
package core_pkg;

    localparam int xlen = 32;

    typedef logic [4:0]      reg_addr_t;
    typedef logic [xlen-1:0] word_t;

    // RV32I major opcodes kept by this core
    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_auipc  = 7'b0010111;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_jal    = 7'b1101111;
    localparam logic [6:0] opc_jalr   = 7'b1100111;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_op_t;

    // instruction formats, none covers unknown opcodes
    typedef enum logic [2:0] {
        kind_r,
        kind_i,
        kind_u,
        kind_b,
        kind_j,
        kind_none
    } inst_kind_t;

    typedef struct packed {
        logic [6:0] opcode;
        logic [2:0] funct3;
        reg_addr_t  rd;
        reg_addr_t  rs1;
        reg_addr_t  rs2;
        word_t      imm;      // already sign extended
        inst_kind_t kind;
        alu_op_t    alu_op;
    } decoded_t;

endpackage
